// File: files.f
+incdir+src
src/rtab_req_pkg.sv
src/rtab_ctrl_pkg.sv
src/rtab_rr_arb.sv
src/rtab_list_state.sv
src/rtab_req_store.sv
src/rtab_pop_fsm.sv
src/rtab_top.sv
verif/rtab_checker.sv
verif/rtab_tb.sv

// File: Bender.yml
package:
  name: rtab

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rtab_req_pkg.sv
      - src/rtab_ctrl_pkg.sv
      - src/rtab_rr_arb.sv
      - src/rtab_list_state.sv
      - src/rtab_req_store.sv
      - src/rtab_pop_fsm.sv
      - src/rtab_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verif/rtab_checker.sv
      - verif/rtab_tb.sv

// File: verif/rtab_tb.sv
/* Directed regression for the replay table. Inputs change on the rising edge
   and outputs are sampled on the falling edge, so one test runs at a time */
`timescale 1ns/1ps
`include "rtab_consts.svh"

module rtab_tb import rtab_req_pkg::*, rtab_ctrl_pkg::*; ();

    localparam int CLK_HALF_NS  = 2;
    localparam int RESET_CYCLES = 5;
    // Longest wait for an expected offer
    localparam int OFFER_WAIT   = 8;
    // Cycle budget per directed test, well above the longest one
    localparam int TEST_CYCLES  = 100;
    localparam int NUM_TESTS    = 6;
    localparam int TIMEOUT_NS   = 2 * (RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * 2 * CLK_HALF_NS;

    localparam rtab_deps_t DEPS_NONE  = '{mshr_hit: 1'b0, mshr_ready: 1'b0};
    localparam rtab_deps_t DEPS_HIT   = '{mshr_hit: 1'b1, mshr_ready: 1'b0};
    localparam rtab_deps_t DEPS_READY = '{mshr_hit: 1'b0, mshr_ready: 1'b1};

    logic        clk;
    logic        rst_n;
    logic        empty;
    logic        full;
    rtab_nline_t check_nline;
    logic        check_hit;
    logic        alloc;
    logic        alloc_and_link;
    rtab_req_t   alloc_req;
    rtab_deps_t  alloc_deps;
    logic        pop_try_valid;
    logic        pop_try;
    rtab_req_t   pop_try_req;
    rtab_ptr_t   pop_try_ptr;
    logic        pop_commit;
    rtab_ptr_t   pop_commit_ptr;
    logic        pop_rback;
    rtab_ptr_t   pop_rback_ptr;
    logic        miss_ready;
    logic        refill;
    rtab_nline_t refill_nline;

    integer    seed;
    int        errors;
    int        test_errors;
    int        tests_run;
    int        tests_failed;
    string     cur_test;
    // Offer seen in the cycle right after a take
    logic      after_valid;
    rtab_req_t after_req;

    rtab_top u_rtab_top (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .empty_o          (empty),
        .full_o           (full),
        .check_nline_i    (check_nline),
        .check_hit_o      (check_hit),
        .alloc_i          (alloc),
        .alloc_and_link_i (alloc_and_link),
        .alloc_req_i      (alloc_req),
        .alloc_deps_i     (alloc_deps),
        .pop_try_valid_o  (pop_try_valid),
        .pop_try_i        (pop_try),
        .pop_try_req_o    (pop_try_req),
        .pop_try_ptr_o    (pop_try_ptr),
        .pop_commit_i     (pop_commit),
        .pop_commit_ptr_i (pop_commit_ptr),
        .pop_rback_i      (pop_rback),
        .pop_rback_ptr_i  (pop_rback_ptr),
        .miss_ready_i     (miss_ready),
        .refill_i         (refill),
        .refill_nline_i   (refill_nline)
    );

    always #CLK_HALF_NS clk = ~clk;

    function automatic rtab_req_t make_req(input rtab_op_e op, input rtab_nline_t line,
                                           input logic [`RTAB_CL_OFFSET_W-1:0] off);
        rtab_req_t req;
        req.op   = op;
        req.addr = {line, off};
        return req;
    endfunction

    // Line index is the address above the offset bits
    function automatic rtab_nline_t line_of(input rtab_req_t req);
        return req.addr[`RTAB_ADDR_W-1:`RTAB_CL_OFFSET_W];
    endfunction

    task automatic pick_line(output rtab_nline_t line);
        line = rtab_nline_t'($random(seed));
    endtask

    task automatic compare_value(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (exp === act) else begin
            $display("Fail %s: %s expected %0h actual %0h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic require(input logic ok, input string msg);
        assert (ok) else begin
            $display("Error in %s: %s", cur_test, msg);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        errors += test_errors;
    endtask

    // One-cycle allocation, check line set to the request's own line
    task automatic alloc_entry(input rtab_req_t req, input rtab_deps_t deps, input logic link);
        @(posedge clk);
        alloc          <= !link;
        alloc_and_link <= link;
        alloc_req      <= req;
        alloc_deps     <= deps;
        check_nline    <= line_of(req);
        @(posedge clk);
        alloc          <= 1'b0;
        alloc_and_link <= 1'b0;
    endtask

    task automatic wait_offer(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < OFFER_WAIT) begin
            @(negedge clk);
            seen = pop_try_valid;
            n++;
        end
        require(seen, $sformatf("no pop-try offer within %0d cycles", OFFER_WAIT));
    endtask

    // Takes the current offer, returns right after the take edge
    task automatic take_offer(output rtab_ptr_t ptr, output rtab_req_t req);
        logic seen;
        wait_offer(seen);
        ptr = pop_try_ptr;
        req = pop_try_req;
        @(posedge clk);
        pop_try <= 1'b1;
        @(posedge clk);
        pop_try <= 1'b0;
    endtask

    // Commit or rollback in the cycle after the take
    task automatic finish_pop(input rtab_ptr_t ptr, input logic rollback,
                              input rtab_req_t new_req, input rtab_deps_t new_deps);
        if (rollback) begin
            pop_rback     <= 1'b1;
            pop_rback_ptr <= ptr;
            alloc_req     <= new_req;
            alloc_deps    <= new_deps;
        end else begin
            pop_commit     <= 1'b1;
            pop_commit_ptr <= ptr;
        end
        @(negedge clk);
        after_valid = pop_try_valid;
        after_req   = pop_try_req;
        @(posedge clk);
        pop_commit <= 1'b0;
        pop_rback  <= 1'b0;
    endtask

    task automatic hold_no_offer(input int cycles);
        logic leaked;
        leaked = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            leaked = leaked | pop_try_valid;
        end
        require(!leaked, "entry was offered while a dependency was still pending");
    endtask

    task automatic refill_line(input rtab_nline_t line);
        @(posedge clk);
        refill       <= 1'b1;
        refill_nline <= line;
        @(posedge clk);
        refill       <= 1'b0;
    endtask

    task automatic signal_miss_ready();
        @(posedge clk);
        miss_ready <= 1'b1;
        @(posedge clk);
        miss_ready <= 1'b0;
    endtask

    task automatic probe_line(input rtab_nline_t line, input logic exp);
        @(posedge clk);
        check_nline <= line;
        @(negedge clk);
        compare_value("check_hit_o", exp, check_hit);
    endtask

    task automatic reset_values();
        start_test("reset_values");
        @(negedge clk);
        compare_value("empty_o", 1, empty);
        compare_value("full_o", 0, full);
        compare_value("pop_try_valid_o", 0, pop_try_valid);
        compare_value("check_hit_o", 0, check_hit);
        report_test();
    endtask

    task automatic alloc_pop_commit();
        rtab_nline_t line;
        rtab_req_t   req;
        rtab_req_t   got;
        rtab_ptr_t   ptr;
        start_test("alloc_pop_commit");
        pick_line(line);
        req = make_req(RTAB_OP_LOAD, line, 4'h8);
        alloc_entry(req, DEPS_NONE, 1'b0);
        // No deps, so offered in the first cycle after the allocation edge
        @(negedge clk);
        compare_value("offer after allocation", 1, pop_try_valid);
        compare_value("empty_o after allocation", 0, empty);
        take_offer(ptr, got);
        compare_value("offered request", req, got);
        finish_pop(ptr, 1'b0, req, DEPS_NONE);
        @(negedge clk);
        compare_value("empty_o after commit", 1, empty);
        probe_line(line, 1'b0);
        report_test();
    endtask

    task automatic dependency_clears();
        rtab_nline_t line;
        rtab_req_t   req;
        rtab_req_t   got;
        rtab_ptr_t   ptr;
        start_test("dependency_clears");
        pick_line(line);
        req = make_req(RTAB_OP_STORE, line, 4'h0);
        alloc_entry(req, DEPS_HIT, 1'b0);
        // Refill of another line leaves mshr_hit pending
        refill_line(rtab_nline_t'(line + 1'b1));
        hold_no_offer(3);
        refill_line(line);
        take_offer(ptr, got);
        compare_value("request after refill", req, got);
        finish_pop(ptr, 1'b0, req, DEPS_NONE);
        req = make_req(RTAB_OP_LOAD, line, 4'h4);
        alloc_entry(req, DEPS_READY, 1'b0);
        hold_no_offer(3);
        signal_miss_ready();
        take_offer(ptr, got);
        compare_value("request after miss ready", req, got);
        finish_pop(ptr, 1'b0, req, DEPS_NONE);
        report_test();
    endtask

    task automatic linked_order();
        rtab_nline_t line;
        rtab_req_t   reqs [3];
        rtab_req_t   got;
        rtab_ptr_t   ptr;
        start_test("linked_order");
        pick_line(line);
        reqs[0] = make_req(RTAB_OP_LOAD, line, 4'h0);
        reqs[1] = make_req(RTAB_OP_STORE, line, 4'h4);
        reqs[2] = make_req(RTAB_OP_LOAD, line, 4'h8);
        alloc_entry(reqs[0], DEPS_NONE, 1'b0);
        alloc_entry(reqs[1], DEPS_NONE, 1'b1);
        alloc_entry(reqs[2], DEPS_NONE, 1'b1);
        for (int i = 0; i < 3; i++) begin
            take_offer(ptr, got);
            compare_value($sformatf("request %0d of the list", i), reqs[i], got);
            finish_pop(ptr, 1'b0, reqs[i], DEPS_NONE);
            // Successor follows the take at once, nothing after the tail
            if (i < 2) begin
                compare_value("successor offered", 1, after_valid);
                compare_value("successor request", reqs[i+1], after_req);
            end else begin
                compare_value("offer after tail", 0, after_valid);
            end
        end
        @(negedge clk);
        compare_value("empty_o after list", 1, empty);
        report_test();
    endtask

    task automatic rollback_replay();
        rtab_nline_t line;
        rtab_req_t   req;
        rtab_req_t   got;
        rtab_ptr_t   ptr;
        rtab_ptr_t   again;
        start_test("rollback_replay");
        pick_line(line);
        req = make_req(RTAB_OP_LOAD, line, 4'h0);
        // Empty table, so the entry lands at index 0
        alloc_entry(req, DEPS_NONE, 1'b0);
        take_offer(ptr, got);
        compare_value("first request", req, got);
        req = make_req(RTAB_OP_STORE, line, 4'hc);
        finish_pop(ptr, 1'b1, req, DEPS_NONE);
        compare_value("offer during rollback cycle", 0, after_valid);
        take_offer(again, got);
        compare_value("rolled-back entry", 0, again);
        compare_value("rolled-back request", req, got);
        // Second rollback waits on the miss handler
        req = make_req(RTAB_OP_LOAD, line, 4'h4);
        finish_pop(again, 1'b1, req, DEPS_READY);
        hold_no_offer(3);
        signal_miss_ready();
        take_offer(ptr, got);
        compare_value("request after miss ready", req, got);
        finish_pop(ptr, 1'b0, req, DEPS_NONE);
        @(negedge clk);
        compare_value("empty_o after rollback test", 1, empty);
        report_test();
    endtask

    task automatic capacity_drain();
        rtab_nline_t              line;
        rtab_req_t                reqs [`RTAB_ENTRIES];
        rtab_req_t                got;
        rtab_ptr_t                ptr;
        logic [`RTAB_ENTRIES-1:0] served;
        start_test("capacity_drain");
        pick_line(line);
        // Empty table, so entry i takes allocation i
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            reqs[i] = make_req(RTAB_OP_LOAD, rtab_nline_t'(line + rtab_nline_t'(i)), 4'h0);
            alloc_entry(reqs[i], DEPS_NONE, 1'b0);
        end
        @(negedge clk);
        compare_value("full_o", 1, full);
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            probe_line(rtab_nline_t'(line + rtab_nline_t'(i)), 1'b1);
        end
        probe_line(rtab_nline_t'(line + rtab_nline_t'(`RTAB_ENTRIES)), 1'b0);
        served = '0;
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            take_offer(ptr, got);
            compare_value("drained request", reqs[ptr], got);
            require(!served[ptr], "entry offered twice while draining");
            served[ptr] = 1'b1;
            finish_pop(ptr, 1'b0, got, DEPS_NONE);
        end
        @(negedge clk);
        compare_value("empty_o after drain", 1, empty);
        compare_value("full_o after drain", 0, full);
        report_test();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, a test is stuck", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed           = 32'h569b_edb4;
        errors         = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        clk            = 1'b0;
        rst_n          = 1'b0;
        check_nline    = '0;
        alloc          = 1'b0;
        alloc_and_link = 1'b0;
        alloc_req      = '0;
        alloc_deps     = '0;
        pop_try        = 1'b0;
        pop_commit     = 1'b0;
        pop_commit_ptr = '0;
        pop_rback      = 1'b0;
        pop_rback_ptr  = '0;
        miss_ready     = 1'b0;
        refill         = 1'b0;
        refill_nline   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        alloc_pop_commit();
        dependency_clears();
        linked_order();
        rollback_replay();
        capacity_drain();
        repeat (2) @(posedge clk);
        $display("Tests run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, tests_failed, errors, u_rtab_top.u_rtab_checker.fail_cnt);
        if (errors == 0 && u_rtab_top.u_rtab_checker.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verif/rtab_checker.sv
/* Protocol assertions on the replay table top, attached by bind. Checks are
   off while reset is asserted */
`timescale 1ns/1ps

module rtab_checker (
    input logic clk_i,
    input logic rst_ni,
    input logic alloc_i,
    input logic alloc_and_link_i,
    input logic full_o,
    input logic pop_try_valid_o,
    input logic pop_try_i,
    input logic pop_commit_i,
    input logic pop_rback_i
);

    // Number of failed protocol assertions
    int fail_cnt = 0;

    // Every take is answered by exactly one of commit or rollback
    take_answered: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (pop_try_valid_o && pop_try_i) |=> (pop_commit_i ^ pop_rback_i))
        else begin
            $error("take not followed by exactly one commit or rollback");
            fail_cnt++;
        end

    no_alloc_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(full_o && (alloc_i || alloc_and_link_i)))
        else begin
            $error("allocation while the table is full");
            fail_cnt++;
        end

    alloc_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(alloc_i && alloc_and_link_i))
        else begin
            $error("alloc and alloc-and-link raised together");
            fail_cnt++;
        end

    // Rollback and take share the request bus
    rback_no_take: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_rback_i && pop_try_valid_o && pop_try_i))
        else begin
            $error("rollback in the same cycle as a take");
            fail_cnt++;
        end

endmodule

bind rtab_top rtab_checker u_rtab_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .alloc_i          (alloc_i),
    .alloc_and_link_i (alloc_and_link_i),
    .full_o           (full_o),
    .pop_try_valid_o  (pop_try_valid_o),
    .pop_try_i        (pop_try_i),
    .pop_commit_i     (pop_commit_i),
    .pop_rback_i      (pop_rback_i)
);

// File: src/rtab_top.sv
/* Replay table top. Requests to one line replay in arrival order, and a
   rollback reuses alloc_req_i and alloc_deps_i for the new request and deps */
`timescale 1ns/1ps
`include "rtab_consts.svh"

module rtab_top import rtab_req_pkg::*, rtab_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    output logic        empty_o,
    output logic        full_o,
    // Check
    input  rtab_nline_t check_nline_i,
    output logic        check_hit_o,
    // Allocation
    input  logic        alloc_i,
    input  logic        alloc_and_link_i,
    input  rtab_req_t   alloc_req_i,
    input  rtab_deps_t  alloc_deps_i,
    // Pop try, then commit or rollback in the next cycle
    output logic        pop_try_valid_o,
    input  logic        pop_try_i,
    output rtab_req_t   pop_try_req_o,
    output rtab_ptr_t   pop_try_ptr_o,
    input  logic        pop_commit_i,
    input  rtab_ptr_t   pop_commit_ptr_i,
    input  logic        pop_rback_i,
    input  rtab_ptr_t   pop_rback_ptr_i,
    // Miss and refill handlers
    input  logic        miss_ready_i,
    input  logic        refill_i,
    input  rtab_nline_t refill_nline_i
);

    rtab_nline_t [`RTAB_ENTRIES-1:0] nline;
    rtab_ptr_t   [`RTAB_ENTRIES-1:0] next;
    rtab_bv_t                        wr_bv;
    rtab_bv_t                        ready;
    rtab_bv_t                        tail;
    rtab_bv_t                        gnt;
    rtab_bv_t                        sel;
    rtab_bv_t                        head_rst;
    rtab_bv_t                        commit_bv;
    rtab_bv_t                        rback_bv;
    logic                            advance;

    assign commit_bv = {`RTAB_ENTRIES{pop_commit_i}} & rtab_ptr_to_bv(pop_commit_ptr_i);
    assign rback_bv  = {`RTAB_ENTRIES{pop_rback_i}} & rtab_ptr_to_bv(pop_rback_ptr_i);

    rtab_req_store u_req_store (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .wr_bv_i  (wr_bv),
        .wr_req_i (alloc_req_i),
        .rd_sel_i (sel),
        .rd_req_o (pop_try_req_o),
        .nline_o  (nline)
    );

    rtab_list_state u_list_state (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .check_nline_i    (check_nline_i),
        .check_hit_o      (check_hit_o),
        .alloc_i          (alloc_i),
        .alloc_and_link_i (alloc_and_link_i),
        .alloc_deps_i     (alloc_deps_i),
        .head_rst_i       (head_rst),
        .rback_bv_i       (rback_bv),
        .commit_bv_i      (commit_bv),
        .refill_i         (refill_i),
        .refill_nline_i   (refill_nline_i),
        .miss_ready_i     (miss_ready_i),
        .nline_i          (nline),
        .wr_bv_o          (wr_bv),
        .ready_o          (ready),
        .tail_o           (tail),
        .next_o           (next),
        .empty_o          (empty_o),
        .full_o           (full_o)
    );

    rtab_rr_arb u_rr_arb (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (ready),
        .advance_i (advance),
        .gnt_o     (gnt)
    );

    rtab_pop_fsm u_pop_fsm (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ready_i         (ready),
        .gnt_i           (gnt),
        .tail_i          (tail),
        .next_i          (next),
        .pop_try_i       (pop_try_i),
        .pop_rback_i     (pop_rback_i),
        .pop_try_valid_o (pop_try_valid_o),
        .sel_o           (sel),
        .pop_try_ptr_o   (pop_try_ptr_o),
        .head_rst_o      (head_rst),
        .advance_o       (advance)
    );

endmodule

// File: src/rtab_pop_fsm.sv
/* Pop-try walk over linked lists. Successors are offered without checking
   their deps, and a take must be answered by commit or rollback next cycle */
`timescale 1ns/1ps
`include "rtab_consts.svh"

module rtab_pop_fsm import rtab_ctrl_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  rtab_bv_t                      ready_i,
    input  rtab_bv_t                      gnt_i,
    input  rtab_bv_t                      tail_i,
    input  rtab_ptr_t [`RTAB_ENTRIES-1:0] next_i,
    input  logic                          pop_try_i,
    input  logic                          pop_rback_i,
    output logic                          pop_try_valid_o,
    output rtab_bv_t                      sel_o,
    output rtab_ptr_t                     pop_try_ptr_o,
    output rtab_bv_t                      head_rst_o,
    output logic                          advance_o
);

    rtab_pop_state_e state_q, state_d;
    rtab_bv_t        nxt_q, nxt_d;
    logic            sel_is_tail;
    logic            take;

    // Head state offers the arbiter winner, the others the held successor
    assign pop_try_valid_o = (state_q == POP_HEAD) ? |ready_i : 1'b1;
    assign sel_o           = (state_q == POP_HEAD) ? gnt_i : nxt_q;
    assign pop_try_ptr_o   = rtab_bv_to_ptr(sel_o);
    assign sel_is_tail     = |(sel_o & tail_i);
    assign take            = pop_try_valid_o & pop_try_i;

    // Taken entry is no longer a head until rolled back
    assign head_rst_o = sel_o & {`RTAB_ENTRIES{pop_try_i}};
    assign advance_o  = (state_q == POP_HEAD) && take && !pop_rback_i;

    always_comb begin
        state_d = state_q;
        nxt_d   = nxt_q;
        case (state_q)
            POP_HEAD: begin
                // A rollback of a previous tail can still arrive here
                if (take && !pop_rback_i && !sel_is_tail) begin
                    state_d = POP_NEXT;
                    nxt_d   = rtab_ptr_to_bv(next_i[pop_try_ptr_o]);
                end
            end
            POP_NEXT, POP_NEXT_WAIT: begin
                if (state_q == POP_NEXT && pop_rback_i) begin
                    state_d = POP_HEAD;
                end else if (take) begin
                    state_d = sel_is_tail ? POP_HEAD : POP_NEXT;
                    nxt_d   = rtab_ptr_to_bv(next_i[pop_try_ptr_o]);
                end else begin
                    // Back-pressure, keep offering the same entry
                    state_d = POP_NEXT_WAIT;
                end
            end
            default: begin
                state_d = POP_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= POP_HEAD;
            nxt_q   <= '0;
        end else begin
            state_q <= state_d;
            nxt_q   <= nxt_d;
        end
    end

endmodule

// File: src/rtab_req_store.sv
/* Request storage, one write per cycle through a mask. The read select
   must be one-hot or zero */
`timescale 1ns/1ps
`include "rtab_consts.svh"

module rtab_req_store import rtab_req_pkg::*, rtab_ctrl_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  rtab_bv_t                        wr_bv_i,
    input  rtab_req_t                       wr_req_i,
    input  rtab_bv_t                        rd_sel_i,
    output rtab_req_t                       rd_req_o,
    output rtab_nline_t [`RTAB_ENTRIES-1:0] nline_o
);

    rtab_req_t req_q [`RTAB_ENTRIES];

    // Also rewritten on rollback
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `RTAB_ENTRIES; i++) begin
                req_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `RTAB_ENTRIES; i++) begin
                if (wr_bv_i[i]) begin
                    req_q[i] <= wr_req_i;
                end
            end
        end
    end

    // Strip the offset to get each entry's line
    for (genvar i = 0; i < `RTAB_ENTRIES; i++) begin : gen_nline
        assign nline_o[i] = req_q[i].addr[`RTAB_CL_OFFSET_W +: `RTAB_NLINE_W];
    end

    // One-hot read mux
    always_comb begin
        rd_req_o = '0;
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            if (rd_sel_i[i]) begin
                rd_req_o = req_q[i];
            end
        end
    end

endmodule

// File: src/rtab_list_state.sv
/* Per-entry list bookkeeping. A link is only legal when check_nline_i matches
   the new line, and a tail that is committed while being linked orphans the new entry */
`timescale 1ns/1ps
`include "rtab_consts.svh"

module rtab_list_state import rtab_req_pkg::*, rtab_ctrl_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // Check
    input  rtab_nline_t                     check_nline_i,
    output logic                            check_hit_o,
    // Allocation
    input  logic                            alloc_i,
    input  logic                            alloc_and_link_i,
    input  rtab_deps_t                      alloc_deps_i,
    // Pop side
    input  rtab_bv_t                        head_rst_i,
    input  rtab_bv_t                        rback_bv_i,
    input  rtab_bv_t                        commit_bv_i,
    // Refill and miss handler
    input  logic                            refill_i,
    input  rtab_nline_t                     refill_nline_i,
    input  logic                            miss_ready_i,
    // Line index of each stored request
    input  rtab_nline_t [`RTAB_ENTRIES-1:0] nline_i,
    // Status
    output rtab_bv_t                        wr_bv_o,
    output rtab_bv_t                        ready_o,
    output rtab_bv_t                        tail_o,
    output rtab_ptr_t   [`RTAB_ENTRIES-1:0] next_o,
    output logic                            empty_o,
    output logic                            full_o
);

    rtab_bv_t                       valid_q;
    rtab_bv_t                       head_q;
    rtab_bv_t                       tail_q;
    rtab_ptr_t  [`RTAB_ENTRIES-1:0] next_q;
    rtab_deps_t [`RTAB_ENTRIES-1:0] deps_q;

    rtab_bv_t free_bv;
    rtab_bv_t alloc_bv;
    rtab_bv_t check_bv;
    rtab_bv_t link_tail_bv;
    rtab_bv_t refill_bv;
    rtab_bv_t nodeps_bv;
    rtab_bv_t head_set;
    rtab_bv_t head_clr;

    // Lowest free entry takes the allocation
    assign free_bv  = ~valid_q & (valid_q + 1'b1);
    assign alloc_bv = free_bv & {`RTAB_ENTRIES{alloc_i | alloc_and_link_i}};

    for (genvar i = 0; i < `RTAB_ENTRIES; i++) begin : gen_match
        assign check_bv[i]  = valid_q[i] && (nline_i[i] == check_nline_i);
        assign refill_bv[i] = refill_i && (nline_i[i] == refill_nline_i);
        assign nodeps_bv[i] = ~|deps_q[i];
    end

    assign check_hit_o = |check_bv;

    // Only the current tail of the matching list gets relinked
    assign link_tail_bv = check_bv & tail_q & {`RTAB_ENTRIES{alloc_and_link_i}};

    // New list or rollback makes a head, any allocation or take drops it first
    assign head_set = (alloc_bv & {`RTAB_ENTRIES{alloc_i}}) | rback_bv_i;
    assign head_clr = alloc_bv | head_rst_i;

    assign wr_bv_o = alloc_bv | rback_bv_i;
    assign ready_o = valid_q & head_q & nodeps_bv;
    assign tail_o  = tail_q;
    assign next_o  = next_q;
    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            next_q  <= '0;
            deps_q  <= '0;
        end else begin
            valid_q <= alloc_bv | (valid_q & ~commit_bv_i);
            head_q  <= head_set | (head_q & ~head_clr);
            // New entries always land at a tail
            tail_q  <= alloc_bv | (tail_q & ~link_tail_bv);
            for (int i = 0; i < `RTAB_ENTRIES; i++) begin
                if (link_tail_bv[i]) begin
                    next_q[i] <= rtab_bv_to_ptr(free_bv);
                end
                // Allocation and rollback both load fresh deps
                if (wr_bv_o[i]) begin
                    deps_q[i] <= alloc_deps_i;
                end else begin
                    deps_q[i].mshr_hit   <= deps_q[i].mshr_hit & ~refill_bv[i];
                    deps_q[i].mshr_ready <= deps_q[i].mshr_ready & ~miss_ready_i;
                end
            end
        end
    end

endmodule

// File: src/rtab_rr_arb.sv
/* Round-robin arbiter over the ready list heads. Grant is one-hot and
   combinational, the priority only moves when advance_i is high */
`timescale 1ns/1ps
`include "rtab_consts.svh"

module rtab_rr_arb import rtab_ctrl_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  rtab_bv_t req_i,
    input  logic     advance_i,
    output rtab_bv_t gnt_o
);

    // First entry to look at, one past the last winner
    rtab_ptr_t ptr_q;
    rtab_ptr_t win_ptr;

    // Circular search starting at ptr_q
    always_comb begin
        int   idx;
        logic found;
        gnt_o = '0;
        found = 1'b0;
        for (int k = 0; k < `RTAB_ENTRIES; k++) begin
            idx = (int'(ptr_q) + k) % `RTAB_ENTRIES;
            if (!found && req_i[idx]) begin
                gnt_o[idx] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    assign win_ptr = rtab_bv_to_ptr(gnt_o);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (advance_i) begin
            // Winner drops to lowest priority, wraps past the last entry
            ptr_q <= win_ptr + 1'b1;
        end
    end

endmodule

// File: src/rtab_ctrl_pkg.sv
/* Table bookkeeping types and pointer conversions */
`include "rtab_consts.svh"

package rtab_ctrl_pkg;

    // Entry index and one-bit-per-entry vector
    typedef logic [$clog2(`RTAB_ENTRIES)-1:0] rtab_ptr_t;
    typedef logic [`RTAB_ENTRIES-1:0]         rtab_bv_t;

    // Pending dependencies of an entry, all must be clear before replay
    typedef struct packed {
        logic mshr_hit;
        logic mshr_ready;
    } rtab_deps_t;

    // Pop-try walk state
    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_NEXT_WAIT
    } rtab_pop_state_e;

    // Index to one-hot
    function automatic rtab_bv_t rtab_ptr_to_bv(input rtab_ptr_t ptr);
        rtab_bv_t bv;
        bv      = '0;
        bv[ptr] = 1'b1;
        return bv;
    endfunction

    // One-hot to index, zero when no bit is set
    function automatic rtab_ptr_t rtab_bv_to_ptr(input rtab_bv_t bv);
        rtab_ptr_t ptr;
        ptr = '0;
        for (int i = 0; i < `RTAB_ENTRIES; i++) begin
            if (bv[i]) begin
                ptr = rtab_ptr_t'(i);
            end
        end
        return ptr;
    endfunction

endpackage

// File: src/rtab_req_pkg.sv
/* Replayed request as stored in the table. Only loads and stores are
   carried, atomics and CMOs are not represented */
`include "rtab_consts.svh"

package rtab_req_pkg;

    // Operation kind of the replayed request
    typedef enum logic {
        RTAB_OP_LOAD  = 1'b0,
        RTAB_OP_STORE = 1'b1
    } rtab_op_e;

    // Full byte address of the request
    typedef logic [`RTAB_ADDR_W-1:0] rtab_addr_t;

    // Cache-line index, address without the offset bits
    typedef logic [`RTAB_NLINE_W-1:0] rtab_nline_t;

    // Stored request record
    typedef struct packed {
        rtab_op_e   op;
        rtab_addr_t addr;
    } rtab_req_t;

endpackage

// File: src/rtab_consts.svh
/* Replay table geometry. RTAB_ENTRIES must be a power of two, and the
   line index width is always derived from the address and offset widths */
`ifndef RTAB_CONSTS_SVH
`define RTAB_CONSTS_SVH

// Number of table entries
`define RTAB_ENTRIES 4

// Request address width in bits
`define RTAB_ADDR_W 32

// Byte offset inside a cache line (16-byte lines)
`define RTAB_CL_OFFSET_W 4

// Cache-line index width
`define RTAB_NLINE_W (`RTAB_ADDR_W - `RTAB_CL_OFFSET_W)

`endif
